//--- daq_capture.f
+incdir+tb
source/daq_pkg.sv
source/line_wr_if.sv
source/sample_packer.sv
source/trigger_detect.sv
source/line_arbiter.sv
source/dram_write_ctrl.sv
source/daq_top.sv
tb/tb_daq_top.sv

//--- tb/tb_tasks.svh
//////////////////////////////
// Testbench helpers, included inside the testbench top module.
// Drive, wait and compare tasks plus the expected line model.
//////////////////////////////

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// prints the error, then ends the run
task automatic fail_run(input string msg);
	$display("%s", msg);
	$display("Simulation FAILED");
	$fatal(1, "%s", msg);
endtask

//////////////////////////////
// compare tasks
//////////////////////////////
task automatic check_line(input string name, input line_t exp, input line_t act);
	if (exp !== act)
		fail_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_addr(input string name, input addr_t exp, input addr_t act);
	if (exp !== act)
		fail_run($sformatf("Mismatch in %s: expected %0d, actual %0d", name, exp, act));
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (exp !== act)
		fail_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
endtask

//////////////////////////////
// stimulus and line model
//////////////////////////////
task automatic fill_random();
	for (int b = 0; b < NUM_BOARDS; b++)
		stim[b] = sample_t'($urandom % TRIGGER_LEVEL);  // stays below the trigger level
endtask

// packs one qualified sample per board, low sample first
task automatic model_sample();
	for (int b = 0; b < NUM_BOARDS; b++)
		part_line[b][part_cnt*SAMPLE_W +: SAMPLE_W] = stim[b];
	if (part_cnt == LINE_SAMPLES - 1) begin
		for (int b = 0; b < NUM_BOARDS; b++) begin
			exp_line_q.push_back(part_line[b]);  // line complete
			exp_board_q.push_back(b);
		end
		part_cnt = 0;
	end else begin
		part_cnt++;
	end
endtask

// one clock of input, applied 1 ns after the rising edge
task automatic drive_cycle(input logic [1:0] sync, input logic [1:0] datak);
	@(posedge clk);
	#1;
	rx_syncstatus = sync;
	rx_datak      = datak;
	for (int b = 0; b < NUM_BOARDS; b++)
		rx_parallel_data[b] = stim[b];
	if (sync == 2'b11 && datak == 2'b00)
		model_sample();  // only qualified samples reach the model
endtask

//////////////////////////////
// write checking
//////////////////////////////
// a write must equal the oldest outstanding line of some board
task automatic match_write(input string name, input addr_t addr, input line_t data);
	board_mask_t seen;
	int          hit;
	seen = '0;
	hit  = -1;
	for (int i = 0; i < exp_line_q.size(); i++) begin
		if (hit < 0 && !seen[exp_board_q[i]]) begin
			if (exp_line_q[i] === data)
				hit = i;
			seen[exp_board_q[i]] = 1'b1;  // later lines of this board are not heads
		end
	end
	if (hit < 0) begin
		fail_run($sformatf("%s: write at address %0d matches no expected board line",
			name, addr));
	end else begin
		exp_line_q.delete(hit);
		exp_board_q.delete(hit);
	end
endtask

// pops recorded writes, checks address order and optionally the data
task automatic collect_writes(input string name, input bit with_data);
	addr_t a;
	line_t d;
	while (wr_addr_q.size() > 0) begin
		a = wr_addr_q.pop_front();
		d = wr_data_q.pop_front();
		if (wr_trig_q.pop_front())
			post_writes++;  // completed while triggered
		check_addr(name, exp_addr, a);
		exp_addr++;
		if (with_data)
			match_write(name, a, d);
	end
endtask

// idle input until every expected line is written
task automatic drain_expected(input string name, input int limit);
	int n;
	n = 0;
	while (exp_line_q.size() > 0 && n < limit) begin
		drive_cycle(2'b00, 2'b00);
		collect_writes(name, 1'b1);
		n++;
	end
	if (exp_line_q.size() > 0)
		fail_run($sformatf("%s: %0d expected lines were never written", name,
			exp_line_q.size()));
endtask

`endif

//--- tb/tb_daq_top.sv
//////////////////////////////
// Testbench for the capture path. Drives eight board streams, models the
// dram wait request and checks each completed write against expected lines.
//////////////////////////////

`timescale 1ns/1ps

module tb_daq_top
	import daq_pkg::*;
();

	logic       clk;
	logic       rst_n;
	logic [1:0] rx_syncstatus;
	logic [1:0] rx_datak;
	sample_t    rx_parallel_data [NUM_BOARDS];
	logic       dram_wait_request;
	addr_t      dram_wr_address;
	line_t      dram_write_data;
	logic       dram_write_enable;
	logic       triggering_status;
	logic       mask_output;

	// stimulus and expected model
	sample_t stim [NUM_BOARDS];       // next sample per board
	line_t   part_line [NUM_BOARDS];  // line being built per board
	int      part_cnt;                // qualified samples in the current line
	line_t   exp_line_q [$];          // outstanding lines, oldest first
	int      exp_board_q [$];         // board of each outstanding line
	addr_t   exp_addr;                // next write address
	int      post_writes;             // writes completed while triggered
	logic    stall_en;                // random wait request on

	// writes completed at the dram
	addr_t wr_addr_q [$];
	line_t wr_data_q [$];
	logic  wr_trig_q [$];

	`include "tb_tasks.svh"

	daq_top i_dut (
		.clk               (clk),
		.rst_n             (rst_n),
		.rx_syncstatus     (rx_syncstatus),
		.rx_datak          (rx_datak),
		.rx_parallel_data  (rx_parallel_data),
		.dram_wait_request (dram_wait_request),
		.dram_wr_address   (dram_wr_address),
		.dram_write_data   (dram_write_data),
		.dram_write_enable (dram_write_enable),
		.triggering_status (triggering_status),
		.mask_output       (mask_output)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;  // 8 ns period

	//////////////////////////////
	// dram model
	//////////////////////////////
	always @(posedge clk) begin
		#1;
		dram_wait_request = stall_en ? 1'($urandom % 2) : 1'b0;
	end

	// sampled mid-cycle where enable and wait request are settled
	always @(negedge clk) begin
		if (rst_n && dram_write_enable && !dram_wait_request) begin
			wr_addr_q.push_back(dram_wr_address);
			wr_data_q.push_back(dram_write_data);
			wr_trig_q.push_back(triggering_status);
		end
	end

	initial begin
		#1ms;
		fail_run("run exceeded the overall time limit");
	end

	//////////////////////////////
	// directed tests
	//////////////////////////////
	task automatic test_reset_state();
		check_bit("reset_state", 1'b0, dram_write_enable);
		check_bit("reset_state", 1'b0, triggering_status);
		check_bit("reset_state", 1'b0, mask_output);
		check_addr("reset_state", '0, dram_wr_address);
	endtask

	// qualification is shared so every board fills a line and board 0 goes first
	task automatic test_single_board();
		line_t exp;
		int    n;
		for (int i = 0; i < LINE_SAMPLES; i++) begin
			fill_random();
			stim[0] = sample_t'(16'h0100 + i);
			exp[i*SAMPLE_W +: SAMPLE_W] = stim[0];
			drive_cycle(2'b11, 2'b00);
		end
		n = 0;
		while (wr_addr_q.size() == 0 && n < 100) begin
			drive_cycle(2'b00, 2'b00);
			n++;
		end
		if (wr_addr_q.size() == 0) begin
			fail_run("single_board: no dram write after a full line");
		end else begin
			check_addr("single_board", '0, wr_addr_q[0]);
			check_line("single_board", exp, wr_data_q[0]);
		end
		drain_expected("single_board", 200);
	endtask

	// two lines per board per round fit the two packer slots
	task automatic test_all_boards();
		stall_en = 1'b1;
		for (int r = 0; r < 3; r++) begin
			for (int i = 0; i < 2 * LINE_SAMPLES; i++) begin
				fill_random();
				if ($urandom % 4 == 0)
					drive_cycle(2'b00, 2'b00);  // idle gap
				drive_cycle(2'b11, 2'b00);
			end
			drain_expected("all_boards", 2000);
		end
		stall_en = 1'b0;
	endtask

	task automatic test_qualification();
		for (int i = 0; i < LINE_SAMPLES; i++) begin
			for (int b = 0; b < NUM_BOARDS; b++)
				stim[b] = sample_t'(TRIGGER_LEVEL + b * 16'h0800 + i);  // at or above level
			case (i % 5)
				0: drive_cycle(2'b01, 2'b00);
				1: drive_cycle(2'b10, 2'b00);
				2: drive_cycle(2'b00, 2'b00);
				3: drive_cycle(2'b11, 2'b01);
				default: drive_cycle(2'b11, 2'b10);
			endcase
			fill_random();
			drive_cycle(2'b11, 2'b00);
		end
		check_bit("qualification", 1'b0, triggering_status);
		drain_expected("qualification", 500);
	endtask

	task automatic test_trigger_stop();
		int n;
		for (int i = 0; i < 6; i++) begin
			fill_random();
			if (i == 5)
				stim[3] = sample_t'(TRIGGER_LEVEL);  // exactly at level
			drive_cycle(2'b11, 2'b00);
		end
		n = 0;
		while (!triggering_status && n < 10) begin
			fill_random();
			drive_cycle(2'b11, 2'b00);
			n++;
		end
		if (!triggering_status)
			fail_run("trigger_stop: triggering_status did not rise");
		n = 0;
		while (post_writes < POST_TRIGGER_LINES && n < 3000) begin
			fill_random();
			drive_cycle(2'b11, 2'b00);
			collect_writes("trigger_stop", 1'b0);  // lines may drop, addresses only
			n++;
		end
		if (post_writes < POST_TRIGGER_LINES)
			fail_run("trigger_stop: post trigger writes did not complete");
		check_bit("trigger_stop", 1'b1, mask_output);
		for (int i = 0; i < 200; i++) begin
			fill_random();
			drive_cycle(2'b11, 2'b00);
		end
		if (wr_addr_q.size() != 0)
			fail_run("trigger_stop: dram write completed after mask_output");
		check_bit("trigger_stop", 1'b0, dram_write_enable);
		exp_line_q.delete();
		exp_board_q.delete();
	endtask

	//////////////////////////////
	// sequence
	//////////////////////////////
	initial begin
		void'($urandom(20198));
		rst_n             = 1'b0;
		rx_syncstatus     = 2'b00;
		rx_datak          = 2'b00;
		dram_wait_request = 1'b0;
		stall_en          = 1'b0;
		part_cnt          = 0;
		exp_addr          = '0;
		post_writes       = 0;
		for (int b = 0; b < NUM_BOARDS; b++) begin
			rx_parallel_data[b] = '0;
			stim[b]             = '0;
			part_line[b]        = '0;
		end
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset_state();
		test_single_board();
		test_all_boards();
		test_qualification();
		test_trigger_stop();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- source/daq_top.sv
//////////////////////////////
// Capture path top level. Eight board packers feed a round-robin
// arbiter and a dram writer, with a threshold detector beside them.
//////////////////////////////

`timescale 1ns/1ps

module daq_top
	import daq_pkg::*;
(
	input  logic       clk,                                // system clock
	input  logic       rst_n,                              // sync reset, active low
	input  logic [1:0] rx_syncstatus,                      // shared link sync flags
	input  logic [1:0] rx_datak,                           // shared control word flags
	input  sample_t    rx_parallel_data [NUM_BOARDS],      // one sample per board
	input  logic       dram_wait_request,                  // dram back-pressure
	output addr_t      dram_wr_address,                    // write address
	output line_t      dram_write_data,                    // write data
	output logic       dram_write_enable,                  // write request
	output logic       triggering_status,                  // trigger seen
	output logic       mask_output                         // capture stopped
);

	//////////////////////////////
	// packer to arbiter wiring
	//////////////////////////////
	board_mask_t line_ready;          // full line per board
	board_mask_t line_take;           // take pulse per board
	board_mask_t sample_valid;        // qualified sample per board
	line_t       lines [NUM_BOARDS];  // offered line per board

	line_wr_if wr_bus ();  // arbiter to writer

	// one packer per board
	for (genvar b = 0; b < NUM_BOARDS; b++) begin : g_board
		sample_packer u_packer (
			.clk           (clk),
			.rst_n         (rst_n),
			.rx_syncstatus (rx_syncstatus),
			.rx_datak      (rx_datak),
			.sample        (rx_parallel_data[b]),
			.line_take     (line_take[b]),
			.line_ready    (line_ready[b]),
			.line          (lines[b]),
			.sample_valid  (sample_valid[b])
		);
	end

	//////////////////////////////
	// trigger, selection and dram write
	//////////////////////////////
	trigger_detect u_trigger (
		.clk               (clk),
		.rst_n             (rst_n),
		.sample_valid      (sample_valid),
		.samples           (rx_parallel_data),
		.triggering_status (triggering_status)
	);

	line_arbiter u_arbiter (
		.clk        (clk),
		.rst_n      (rst_n),
		.line_ready (line_ready),
		.lines      (lines),
		.line_take  (line_take),
		.wr         (wr_bus.src)
	);

	dram_write_ctrl u_writer (
		.clk               (clk),
		.rst_n             (rst_n),
		.triggering_status (triggering_status),
		.dram_wait_request (dram_wait_request),
		.dram_wr_address   (dram_wr_address),
		.dram_write_data   (dram_write_data),
		.dram_write_enable (dram_write_enable),
		.mask_output       (mask_output),
		.wr                (wr_bus.dst)
	);

endmodule

//--- source/dram_write_ctrl.sv
//////////////////////////////
// Dram address and write controller. Single-beat writes to consecutive
// addresses from 0, held until wait request drops. Stops a fixed number
// of writes after the trigger and raises the mask output.
//////////////////////////////

`timescale 1ns/1ps

module dram_write_ctrl
	import daq_pkg::*;
(
	input  logic   clk,                // system clock
	input  logic   rst_n,              // sync reset, active low
	input  logic   triggering_status,  // from the threshold detector
	input  logic   dram_wait_request,  // dram not ready to take the write
	output addr_t  dram_wr_address,    // current write address
	output line_t  dram_write_data,    // line being written
	output logic   dram_write_enable,  // write pending
	output logic   mask_output,        // capture finished after trigger
	line_wr_if.dst wr                  // line from the arbiter
);

	logic                  accept;    // line taken from the arbiter
	logic                  done;      // dram completes the pending write
	logic                  last_one;  // this completion ends the capture
	logic [POST_CNT_W-1:0] post_cnt;  // writes completed while triggered

	//////////////////////////////
	// handshakes
	//////////////////////////////
	// no new line while a write is pending or after the stop
	assign wr.ready = !dram_write_enable && !mask_output;
	assign accept   = wr.valid && wr.ready;
	assign done     = dram_write_enable && !dram_wait_request;
	assign last_one = triggering_status && (post_cnt == POST_CNT_W'(POST_TRIGGER_LINES - 1));

	//////////////////////////////
	// write state
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dram_write_enable <= 1'b0;
			dram_wr_address   <= '0;
		end else begin
			if (accept)
				dram_write_enable <= 1'b1;  // start on the edge after transfer
			else if (done)
				dram_write_enable <= 1'b0;
			if (done)
				dram_wr_address <= dram_wr_address + 1'b1;  // next word
		end
	end

	// post trigger count and stop
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			post_cnt    <= '0;
			mask_output <= 1'b0;
		end else if (done && triggering_status) begin
			post_cnt <= post_cnt + 1'b1;
			if (last_one)
				mask_output <= 1'b1;  // writer stays idle from here on
		end
	end

	// write data, stable while enable is high
	always_ff @(posedge clk) begin
		if (accept)
			dram_write_data <= wr.line;
	end

endmodule

//--- source/line_arbiter.sv
//////////////////////////////
// Round-robin line selector between the packers and the dram writer.
// Takes one ready line at a time and holds it on the interface until accepted.
//////////////////////////////

`timescale 1ns/1ps

module line_arbiter
	import daq_pkg::*;
(
	input  logic        clk,                 // system clock
	input  logic        rst_n,               // sync reset, active low
	input  board_mask_t line_ready,          // packer holds a full line
	input  line_t       lines [NUM_BOARDS],  // offered line per board
	output board_mask_t line_take,           // one-hot take pulse to the packers
	line_wr_if.src      wr                   // selected line towards the writer
);

	board_t ptr;        // first board to look at
	board_t sel;        // chosen board
	logic   found;      // some board is ready
	logic   slot_open;  // interface empty or being emptied this cycle
	logic   take;       // a line moves into the interface

	assign slot_open = !wr.valid || wr.ready;
	assign take      = slot_open && found;

	//////////////////////////////
	// rotating priority search
	//////////////////////////////
	always_comb begin
		board_t idx;
		found = 1'b0;
		sel   = ptr;
		for (int i = 0; i < NUM_BOARDS; i++) begin
			idx = board_t'(ptr + i);  // wraps around the board count
			if (!found && line_ready[idx]) begin
				found = 1'b1;
				sel   = idx;
			end
		end
	end

	assign line_take = take ? (board_mask_t'(1) << sel) : '0;

	// valid and pointer
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr.valid <= 1'b0;
			ptr      <= '0;
		end else if (take) begin
			wr.valid <= 1'b1;
			ptr      <= sel + 1'b1;  // start after the board just served
		end else if (wr.ready) begin
			wr.valid <= 1'b0;  // line went to the writer
		end
	end

	// latched line and its source board
	always_ff @(posedge clk) begin
		if (take) begin
			wr.line  <= lines[sel];
			wr.board <= sel;
		end
	end

endmodule

//--- source/trigger_detect.sv
//////////////////////////////
// Threshold detector over all boards.
// Raises a sticky trigger flag after the first qualified sample at or above level.
//////////////////////////////

`timescale 1ns/1ps

module trigger_detect
	import daq_pkg::*;
(
	input  logic        clk,                     // system clock
	input  logic        rst_n,                   // sync reset, active low
	input  board_mask_t sample_valid,            // qualified sample per board
	input  sample_t     samples [NUM_BOARDS],    // current sample per board
	output logic        triggering_status        // set on first hit, held till reset
);

	board_mask_t hit;      // per-board threshold hit
	logic        any_hit;  // some board crossed the level

	// compare all boards in the same cycle
	always_comb begin
		for (int b = 0; b < NUM_BOARDS; b++) begin
			hit[b] = sample_valid[b] && (samples[b] >= sample_t'(TRIGGER_LEVEL));
		end
	end

	assign any_hit = |hit;

	//////////////////////////////
	// sticky flag
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n)
			triggering_status <= 1'b0;
		else if (any_hit)
			triggering_status <= 1'b1;  // stays until reset
	end

endmodule

//--- source/sample_packer.sv
//////////////////////////////
// Per-board packer. Qualifies samples and packs 16 of them into a line.
// Two line slots, the older full one is offered to the arbiter.
//////////////////////////////

`timescale 1ns/1ps

module sample_packer
	import daq_pkg::*;
(
	input  logic       clk,            // system clock
	input  logic       rst_n,          // sync reset, active low
	input  logic [1:0] rx_syncstatus,  // link sync flags, all ones when aligned
	input  logic [1:0] rx_datak,       // control word flags, zero for data
	input  sample_t    sample,         // sample from this board
	input  logic       line_take,      // arbiter consumes the offered line
	output logic       line_ready,     // a full line is waiting
	output line_t      line,           // offered line
	output logic       sample_valid    // current sample is qualified
);

	//////////////////////////////
	// slot state
	//////////////////////////////
	line_t                   slot_data [2];  // two line slots
	logic [1:0]              slot_full;      // full flag per slot
	logic                    wr_sel;         // slot being filled
	logic                    rd_sel;         // oldest full slot
	logic [SAMPLE_CNT_W-1:0] cnt;            // sample position inside current line
	logic                    drop_line;      // current line is being discarded
	logic                    line_start;     // next qualified sample opens a line
	logic                    drop_now;       // discard the current sample
	logic                    store;          // write the current sample into a slot
	logic                    line_done;      // last sample of a line is stored

	// a sample counts only with link aligned and a data word
	assign sample_valid = (rx_syncstatus == 2'b11) && (rx_datak == 2'b00);

	assign line_start = (cnt == '0);
	// drop decision is taken once at the line start, so lines stay whole
	assign drop_now   = line_start ? slot_full[wr_sel] : drop_line;
	assign store      = sample_valid && !drop_now;
	assign line_done  = store && (cnt == SAMPLE_CNT_W'(LINE_SAMPLES - 1));

	assign line_ready = slot_full[rd_sel];  // older slot offered first
	assign line       = slot_data[rd_sel];

	//////////////////////////////
	// position counter
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt       <= '0;
			drop_line <= 1'b0;
		end else if (sample_valid) begin
			cnt <= cnt + 1'b1;  // wraps after the 16th sample
			if (line_start)
				drop_line <= slot_full[wr_sel];  // no free slot, skip this line
		end
	end

	// slot bookkeeping
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot_full <= 2'b00;
			wr_sel    <= 1'b0;
			rd_sel    <= 1'b0;
		end else begin
			if (line_done) begin
				slot_full[wr_sel] <= 1'b1;  // line complete
				wr_sel            <= ~wr_sel;
			end
			if (line_take && line_ready) begin
				slot_full[rd_sel] <= 1'b0;  // line handed to the arbiter
				rd_sel            <= ~rd_sel;
			end
		end
	end

	// sample payload, low sample first
	always_ff @(posedge clk) begin
		if (store)
			slot_data[wr_sel][cnt*SAMPLE_W +: SAMPLE_W] <= sample;
	end

endmodule

//--- source/line_wr_if.sv
//////////////////////////////
// Line transfer from the arbiter to the dram write controller.
// The arbiter drives through src, the writer receives through dst.
//////////////////////////////

`timescale 1ns/1ps

interface line_wr_if;

	logic            valid;  // arbiter holds a line for the writer
	logic            ready;  // writer has no write pending
	daq_pkg::line_t  line;   // packed line, sample 0 in the low bits
	daq_pkg::board_t board;  // board that produced the line

	// arbiter side
	modport src (
		output valid,
		output line,
		output board,
		input  ready
	);

	// writer side
	modport dst (
		input  valid,
		input  line,
		input  board,
		output ready
	);

endinterface

//--- source/daq_pkg.sv
//////////////////////////////
// Shared sizes, trigger settings and data types for the capture path.
// Imported by wildcard in the header of each RTL module.
//////////////////////////////

package daq_pkg;

	//////////////////////////////
	// board and sample geometry
	//////////////////////////////
	localparam int NUM_BOARDS   = 8;                        // board channels
	localparam int BOARD_W      = 3;                        // bits of a board index
	localparam int SAMPLE_W     = 16;                       // bits per sample
	localparam int LINE_SAMPLES = 16;                       // samples packed per line
	localparam int LINE_W       = SAMPLE_W * LINE_SAMPLES;  // 256 bit line
	localparam int SAMPLE_CNT_W = $clog2(LINE_SAMPLES);     // position counter inside a line

	// dram side
	localparam int ADDR_W = 25;  // word address into dram

	//////////////////////////////
	// trigger settings
	//////////////////////////////
	localparam int TRIGGER_LEVEL      = 16'h8000;                     // hit when sample >= level
	localparam int POST_TRIGGER_LINES = 4;                            // writes kept after trigger
	localparam int POST_CNT_W         = $clog2(POST_TRIGGER_LINES + 1);  // post trigger counter

	//////////////////////////////
	// data types
	//////////////////////////////
	typedef logic [SAMPLE_W-1:0]   sample_t;      // one board sample
	typedef logic [LINE_W-1:0]     line_t;        // one packed line
	typedef logic [ADDR_W-1:0]     addr_t;        // dram word address
	typedef logic [BOARD_W-1:0]    board_t;       // board index
	typedef logic [NUM_BOARDS-1:0] board_mask_t;  // one bit per board

endpackage
